// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= trig_acq_tb
LINT_TOP  ?= trig_acq_top
FLIST     ?= trig_acq.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== source/edge_hit_detector.sv ====
`timescale 1ns/1ps

module edge_hit_detector (
    input  logic                                      ACLK,
    input  logic                                      rst_n,
    input  logic                                      set_config,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0]       lg_data,
    input  logic                                      data_valid,
    input  logic signed [trig_acq_pkg::SAMPLE_WIDTH-1:0] rise_thresh,
    input  logic signed [trig_acq_pkg::SAMPLE_WIDTH-1:0] fall_thresh,
    output logic                                      hit_start,
    output logic                                      hit_end,
    output logic                                      valid_d
);
    import trig_acq_pkg::*;

    logic signed [SAMPLE_WIDTH-1:0] sample [SAMPLES_PER_CLK];
    logic [SAMPLES_PER_CLK-1:0]     over;      // Above rise_thresh
    logic [SAMPLES_PER_CLK-1:0]     under;     // Below fall_thresh
    logic [SAMPLES_PER_CLK-1:0]     rise;
    logic                           last_over; // Last lane of previous valid word

    always_comb begin
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            sample[i] = $signed(lg_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
            over[i]   = sample[i] > rise_thresh;
            under[i]  = sample[i] < fall_thresh;
        end
    end

    // Lane 0 is the oldest sample of the word
    always_comb begin
        rise[0] = over[0] & ~last_over; // Crossing at word boundary
        for (int i = 1; i < SAMPLES_PER_CLK; i++) begin
            rise[i] = over[i] & ~over[i-1];
        end
    end

    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            hit_start <= 1'b0;
            hit_end   <= 1'b0;
            valid_d   <= 1'b0;
            last_over <= 1'b0;
        end else begin
            hit_start <= data_valid & (|rise);
            hit_end   <= data_valid & (&under);
            valid_d   <= data_valid;
            if (data_valid) begin
                last_over <= over[SAMPLES_PER_CLK-1];
            end
        end
    end

endmodule

// ==== source/gain_selector.sv ====
`timescale 1ns/1ps

module gain_selector (
    input  logic                                ACLK,
    input  logic                                rst_n,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0] lg_data,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0] hg_data,
    input  logic                                gain_mode,
    input  logic [trig_acq_pkg::LEN_WIDTH-1:0]  pre_len,
    output logic [trig_acq_pkg::WORD_WIDTH-1:0] out_data
);
    import trig_acq_pkg::*;

    // Two stages match the trigger latency
    logic [WORD_WIDTH-1:0] lg_s1;
    logic [WORD_WIDTH-1:0] lg_s2;
    logic [WORD_WIDTH-1:0] hg_s1;
    logic [WORD_WIDTH-1:0] hg_s2;
    logic [WORD_WIDTH-1:0] lg_dly [MAX_PRE_LEN];
    logic [WORD_WIDTH-1:0] hg_dly [MAX_PRE_LEN];
    logic [WORD_WIDTH-1:0] lg_tap;
    logic [WORD_WIDTH-1:0] hg_tap;

    always_ff @(posedge ACLK) begin
        if (!rst_n) begin
            lg_s1 <= '0;
            lg_s2 <= '0;
            hg_s1 <= '0;
            hg_s2 <= '0;
            for (int k = 0; k < MAX_PRE_LEN; k++) begin
                lg_dly[k] <= '0;
                hg_dly[k] <= '0;
            end
        end else begin
            lg_s1     <= lg_data;
            lg_s2     <= lg_s1;
            hg_s1     <= hg_data;
            hg_s2     <= hg_s1;
            lg_dly[0] <= lg_s2;
            hg_dly[0] <= hg_s2;
            for (int k = 1; k < MAX_PRE_LEN; k++) begin
                lg_dly[k] <= lg_dly[k-1];
                hg_dly[k] <= hg_dly[k-1];
            end
        end
    end

    // Tap at pre_len, zero means straight from stage two
    always_comb begin
        lg_tap = lg_s2;
        hg_tap = hg_s2;
        for (int k = 0; k < MAX_PRE_LEN; k++) begin
            if (pre_len == LEN_WIDTH'(k + 1)) begin
                lg_tap = lg_dly[k];
                hg_tap = hg_dly[k];
            end
        end
    end

    assign out_data = gain_mode ? lg_tap : hg_tap; // Low gain while saturated

endmodule

// ==== source/saturation_detector.sv ====
`timescale 1ns/1ps

module saturation_detector (
    input  logic                                ACLK,
    input  logic                                rst_n,
    input  logic                                set_config,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0] hg_data,
    input  logic                                data_valid,
    input  logic                                trig_fall,
    output logic                                sat_hit,
    output logic                                gain_mode
);
    import trig_acq_pkg::*;

    logic [ADC_WIDTH-1:0]       adc_code [SAMPLES_PER_CLK];
    logic [SAMPLES_PER_CLK-1:0] lane_sat;

    always_comb begin
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            adc_code[i] = hg_data[i*SAMPLE_WIDTH + ADC_LSB +: ADC_WIDTH];
            lane_sat[i] = adc_code[i] == SAT_CODE;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            sat_hit <= 1'b0;
        end else begin
            sat_hit <= data_valid & (|lane_sat);
        end
    end

    // Low-gain mode held until the window closes, new saturation wins
    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            gain_mode <= 1'b0;
        end else if (sat_hit) begin
            gain_mode <= 1'b1;
        end else if (trig_fall) begin
            gain_mode <= 1'b0;
        end
    end

endmodule

// ==== source/trig_acq_pkg.sv ====
package trig_acq_pkg;

    // Bus word layout
    localparam int SAMPLES_PER_CLK = 4;
    localparam int SAMPLE_WIDTH = 16;
    localparam int WORD_WIDTH = SAMPLES_PER_CLK * SAMPLE_WIDTH;

    // ADC code sits left aligned in each high-gain sample
    localparam int ADC_WIDTH = 12;
    localparam int ADC_LSB = SAMPLE_WIDTH - ADC_WIDTH;
    localparam logic [ADC_WIDTH-1:0] SAT_CODE = ADC_WIDTH'((1 << (ADC_WIDTH - 1)) - 1);

    // Acquisition lengths in words
    localparam int MAX_PRE_LEN = 8;
    localparam int MAX_POST_LEN = 8;
    localparam int MAX_LEN = (MAX_PRE_LEN > MAX_POST_LEN) ? MAX_PRE_LEN : MAX_POST_LEN;
    localparam int LEN_WIDTH = $clog2(MAX_LEN + 1);

    // Extension counter holds pre + post + 1
    localparam int EXT_WIDTH = $clog2(MAX_PRE_LEN + MAX_POST_LEN + 2);

endpackage

// ==== source/trig_acq_top.sv ====
`timescale 1ns/1ps

module trig_acq_top (
    input  logic                                         ACLK,
    input  logic                                         rst_n,
    input  logic                                         set_config,
    input  logic                                         stop,
    input  logic                                         data_valid,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0]          lg_data,
    input  logic [trig_acq_pkg::WORD_WIDTH-1:0]          hg_data,
    input  logic signed [trig_acq_pkg::SAMPLE_WIDTH-1:0] rise_thresh,
    input  logic signed [trig_acq_pkg::SAMPLE_WIDTH-1:0] fall_thresh,
    input  logic [trig_acq_pkg::LEN_WIDTH-1:0]           pre_len,
    input  logic [trig_acq_pkg::LEN_WIDTH-1:0]           post_len,
    output logic [trig_acq_pkg::WORD_WIDTH-1:0]          out_data,
    output logic                                         out_valid,
    output logic                                         gain_mode
);
    import trig_acq_pkg::*;

    logic hit_start;
    logic hit_end;
    logic valid_d;
    logic sat_hit;
    logic trig_fall;

    edge_hit_detector u_edge (
        .ACLK        (ACLK),
        .rst_n       (rst_n),
        .set_config  (set_config),
        .lg_data     (lg_data),
        .data_valid  (data_valid),
        .rise_thresh (rise_thresh),
        .fall_thresh (fall_thresh),
        .hit_start   (hit_start),
        .hit_end     (hit_end),
        .valid_d     (valid_d)
    );

    saturation_detector u_sat (
        .ACLK       (ACLK),
        .rst_n      (rst_n),
        .set_config (set_config),
        .hg_data    (hg_data),
        .data_valid (data_valid),
        .trig_fall  (trig_fall),
        .sat_hit    (sat_hit),
        .gain_mode  (gain_mode)
    );

    trigger_window u_window (
        .ACLK       (ACLK),
        .rst_n      (rst_n),
        .set_config (set_config),
        .stop       (stop),
        .hit_start  (hit_start),
        .hit_end    (hit_end),
        .sat_hit    (sat_hit),
        .valid_d    (valid_d),
        .pre_len    (pre_len),
        .post_len   (post_len),
        .gate       (out_valid),
        .trig_fall  (trig_fall)
    );

    gain_selector u_select (
        .ACLK      (ACLK),
        .rst_n     (rst_n),
        .lg_data   (lg_data),
        .hg_data   (hg_data),
        .gain_mode (gain_mode),
        .pre_len   (pre_len),
        .out_data  (out_data)
    );

endmodule

// ==== source/trigger_window.sv ====
`timescale 1ns/1ps

module trigger_window (
    input  logic                               ACLK,
    input  logic                               rst_n,
    input  logic                               set_config,
    input  logic                               stop,
    input  logic                               hit_start,
    input  logic                               hit_end,
    input  logic                               sat_hit,
    input  logic                               valid_d,
    input  logic [trig_acq_pkg::LEN_WIDTH-1:0] pre_len,
    input  logic [trig_acq_pkg::LEN_WIDTH-1:0] post_len,
    output logic                               gate,
    output logic                               trig_fall
);
    import trig_acq_pkg::*;

    logic                 trigger;
    logic                 gate_d;
    logic [EXT_WIDTH-1:0] ext_cnt;  // Remaining gated cycles after trigger
    logic [EXT_WIDTH-1:0] ext_len;
    logic                 start;

    assign ext_len = EXT_WIDTH'(pre_len) + EXT_WIDTH'(post_len) + EXT_WIDTH'(1);
    assign start   = (hit_start | sat_hit) & ~stop & valid_d;

    // Set has priority over clear
    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            trigger <= 1'b0;
        end else if (start) begin
            trigger <= 1'b1;
        end else if (hit_end || !valid_d) begin
            trigger <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            ext_cnt <= '0;
        end else if (trigger) begin
            ext_cnt <= ext_len; // Reload, restarts on retrigger
        end else if (ext_cnt != '0) begin
            ext_cnt <= ext_cnt - EXT_WIDTH'(1);
        end
    end

    always_ff @(posedge ACLK) begin
        if (!rst_n || set_config) begin
            gate_d <= 1'b0;
        end else begin
            gate_d <= gate;
        end
    end

    assign gate      = trigger | (ext_cnt != '0);
    assign trig_fall = gate_d & ~gate; // First cycle with gate low

endmodule

// ==== trig_acq.f ====
source/trig_acq_pkg.sv
source/edge_hit_detector.sv
source/saturation_detector.sv
source/trigger_window.sv
source/gain_selector.sv
source/trig_acq_top.sv
verif/trig_acq_tb.sv

// ==== verif/trig_acq_tb.sv ====
`timescale 1ns/1ps

module trig_acq_tb;
    import trig_acq_pkg::*;

    localparam int TIMEOUT_CYC = 3000; // About 1800 cycles of tests plus margin
    localparam int HIST_LEN = TIMEOUT_CYC + 8;

    logic                           ACLK = 1'b0;
    logic                           rst_n;
    logic                           set_config;
    logic                           stop;
    logic                           data_valid;
    logic [WORD_WIDTH-1:0]          lg_data;
    logic [WORD_WIDTH-1:0]          hg_data;
    logic signed [SAMPLE_WIDTH-1:0] rise_thresh;
    logic signed [SAMPLE_WIDTH-1:0] fall_thresh;
    logic [LEN_WIDTH-1:0]           pre_len;
    logic [LEN_WIDTH-1:0]           post_len;
    logic [WORD_WIDTH-1:0]          out_data;
    logic                           out_valid;
    logic                           gain_mode;

    // Driven values, indexed by the edge that samples them
    bit                           h_rst [HIST_LEN];
    bit                           h_cfg [HIST_LEN];
    bit                           h_stop [HIST_LEN];
    bit                           h_dv [HIST_LEN];
    bit [WORD_WIDTH-1:0]          h_lg [HIST_LEN];
    bit [WORD_WIDTH-1:0]          h_hg [HIST_LEN];
    bit signed [SAMPLE_WIDTH-1:0] h_rise [HIST_LEN];
    bit signed [SAMPLE_WIDTH-1:0] h_fall [HIST_LEN];
    bit [LEN_WIDTH-1:0]           h_pre [HIST_LEN];
    bit [LEN_WIDTH-1:0]           h_post [HIST_LEN];

    logic m_trig;
    logic m_gate;
    logic m_gate_old;
    logic m_gm;
    logic m_hs;
    logic m_he;
    logic m_sh;
    logic m_vd;
    logic m_last_over;
    int   m_ext;

    int                             cyc = 0;
    integer                         seed;
    string                          test_name;
    logic                           rst_lvl;
    logic                           stop_lvl;
    logic signed [SAMPLE_WIDTH-1:0] cfg_rise;
    logic signed [SAMPLE_WIDTH-1:0] cfg_fall;
    logic [LEN_WIDTH-1:0]           cfg_pre;
    logic [LEN_WIDTH-1:0]           cfg_post;
    int                             pre_set [3] = '{0, 3, 8};
    int                             post_set [3] = '{2, 5, 8};
    int                             idx;
    logic [WORD_WIDTH-1:0]          exp_word;

    trig_acq_top trig_acq_top_i (
        .ACLK        (ACLK),
        .rst_n       (rst_n),
        .set_config  (set_config),
        .stop        (stop),
        .data_valid  (data_valid),
        .lg_data     (lg_data),
        .hg_data     (hg_data),
        .rise_thresh (rise_thresh),
        .fall_thresh (fall_thresh),
        .pre_len     (pre_len),
        .post_len    (post_len),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .gain_mode   (gain_mode)
    );

    always #10 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("Test failed");
            $fatal(1, "simulation did not finish in time");
        end
    end

    // Expected state after edge n, built from the trigger rules
    function automatic void model_edge(input int n);
        logic               start;
        logic               fall_seen;
        logic               prev_over;
        logic               hit;
        logic               low_all;
        logic               sat;
        logic signed [15:0] s;
        if (!h_rst[n] || h_cfg[n]) begin
            m_trig      = 1'b0;
            m_gate      = 1'b0;
            m_gate_old  = 1'b0;
            m_gm        = 1'b0;
            m_hs        = 1'b0;
            m_he        = 1'b0;
            m_sh        = 1'b0;
            m_vd        = 1'b0;
            m_last_over = 1'b0;
            m_ext       = 0;
            return;
        end
        start     = (m_hs || m_sh) && !h_stop[n] && m_vd;
        fall_seen = m_gate_old && !m_gate;
        if (m_sh) begin
            m_gm = 1'b1;
        end else if (fall_seen) begin
            m_gm = 1'b0;
        end
        if (m_trig) begin
            m_ext = int'(h_pre[n]) + int'(h_post[n]) + 1; // Window tail after the end word
        end else if (m_ext > 0) begin
            m_ext = m_ext - 1;
        end
        if (start) begin
            m_trig = 1'b1;
        end else if (m_he || !m_vd) begin
            m_trig = 1'b0;
        end
        m_gate_old = m_gate;
        m_gate     = m_trig || (m_ext > 0);
        prev_over  = m_last_over; // Serial scan across the word boundary
        hit        = 1'b0;
        low_all    = 1'b1;
        sat        = 1'b0;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            s = h_lg[n][i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            if (s > h_rise[n] && !prev_over) begin
                hit = 1'b1;
            end
            prev_over = s > h_rise[n];
            if (!(s < h_fall[n])) begin
                low_all = 1'b0;
            end
            if (h_hg[n][i*SAMPLE_WIDTH + ADC_LSB +: ADC_WIDTH] == SAT_CODE) begin
                sat = 1'b1;
            end
        end
        m_vd = h_dv[n];
        m_hs = h_dv[n] && hit;
        m_he = h_dv[n] && low_all;
        m_sh = h_dv[n] && sat;
        if (h_dv[n]) begin
            m_last_over = prev_over;
        end
    endfunction

    task automatic check_value(input string what, input logic [WORD_WIDTH-1:0] expected,
                               input logic [WORD_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Test failed");
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $fatal(1);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge ACLK) begin
        if (cyc > 0) begin
            model_edge(cyc);
            check_value("out_valid", WORD_WIDTH'(m_gate), WORD_WIDTH'(out_valid));
            check_value("gain_mode", WORD_WIDTH'(m_gm), WORD_WIDTH'(gain_mode));
            if (m_gate) begin
                idx      = cyc - 1 - int'(h_pre[cyc + 1]); // pre_len is live at the tap
                exp_word = m_gm ? h_lg[idx] : h_hg[idx];
                check_value("out_data", exp_word, out_data);
            end
        end
    end

    function automatic logic [WORD_WIDTH-1:0] word4(input int a, input int b, input int c,
                                                    input int d);
        return {16'(d), 16'(c), 16'(b), 16'(a)}; // Lane 0 oldest
    endfunction

    function automatic logic [WORD_WIDTH-1:0] hg_filler(input int k);
        return word4((k * 4) & 'hfff, (k * 4 + 1) & 'hfff, (k * 4 + 2) & 'hfff,
                     (k * 4 + 3) & 'hfff);
    endfunction

    task automatic drive_now(input logic dv, input logic cfg, input logic [WORD_WIDTH-1:0] lg,
                             input logic [WORD_WIDTH-1:0] hg, input int k);
        rst_n       = rst_lvl;
        set_config  = cfg;
        stop        = stop_lvl;
        data_valid  = dv;
        lg_data     = lg;
        hg_data     = hg;
        rise_thresh = cfg_rise;
        fall_thresh = cfg_fall;
        pre_len     = cfg_pre;
        post_len    = cfg_post;
        h_rst[k]    = rst_lvl;
        h_cfg[k]    = cfg;
        h_stop[k]   = stop_lvl;
        h_dv[k]     = dv;
        h_lg[k]     = lg;
        h_hg[k]     = hg;
        h_rise[k]   = cfg_rise;
        h_fall[k]   = cfg_fall;
        h_pre[k]    = cfg_pre;
        h_post[k]   = cfg_post;
    endtask

    task automatic step(input logic dv, input logic cfg, input logic [WORD_WIDTH-1:0] lg,
                        input logic [WORD_WIDTH-1:0] hg);
        @(posedge ACLK);
        #2;
        drive_now(dv, cfg, lg, hg, cyc + 1);
    endtask

    task automatic send(input logic [WORD_WIDTH-1:0] lg);
        step(1'b1, 1'b0, lg, hg_filler(cyc));
    endtask

    task automatic send_sat(input logic [WORD_WIDTH-1:0] lg);
        logic [WORD_WIDTH-1:0] hg;
        hg = hg_filler(cyc);
        hg[SAMPLE_WIDTH +: SAMPLE_WIDTH] = {SAT_CODE, 4'h3}; // Full scale on lane 1
        step(1'b1, 1'b0, lg, hg);
    endtask

    task automatic settle(input int n);
        repeat (n) send(word4(0, 0, 0, 0));
    endtask

    task automatic configure(input int rise, input int fall, input int pre, input int post);
        cfg_rise = 16'(rise);
        cfg_fall = 16'(fall);
        cfg_pre  = 4'(pre);
        cfg_post = 4'(post);
        step(1'b0, 1'b1, '0, '0);
    endtask

    task automatic pulse();
        send(word4(0, 500, 1500, 1600)); // Crossing at lane 2
        repeat (3) send(word4(1500, 1500, 1500, 1500));
        send(word4(0, 0, 0, 0));
    endtask

    task automatic random_word();
        logic [WORD_WIDTH-1:0] lg;
        logic [WORD_WIDTH-1:0] hg;
        logic                  dv;
        int                    lane;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            lg[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'($random(seed) % 3000);
            hg[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'($random(seed) % 3000);
        end
        if ($unsigned($random(seed)) % 24 == 0) begin
            lane = int'($unsigned($random(seed)) % 4);
            hg[lane*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 16'h7ff0 | 16'($unsigned($random(seed)) % 16);
        end
        if ($unsigned($random(seed)) % 40 == 0) begin
            stop_lvl = ~stop_lvl;
        end
        dv = ($unsigned($random(seed)) % 12) != 0;
        step(dv, 1'b0, lg, hg);
    endtask

    initial begin
        seed      = 32'h50f2_857e;
        test_name = "reset";
        rst_lvl   = 1'b0;
        stop_lvl  = 1'b0;
        cfg_rise  = 16'sd1000;
        cfg_fall  = 16'sd200;
        cfg_pre   = '0;
        cfg_post  = 4'd2;
        drive_now(1'b0, 1'b0, '0, '0, 1);
        repeat (7) step(1'b0, 1'b0, '0, '0);
        rst_lvl = 1'b1;
        settle(4);

        for (int t = 0; t < 3; t++) begin
            test_name = $sformatf("rise_pre%0d", pre_set[t]);
            configure(1000, 200, pre_set[t], post_set[t]);
            settle(10);
            pulse();
            settle(pre_set[t] + post_set[t] + 6);
        end

        test_name = "word_boundary";
        configure(1000, 200, 2, 1);
        settle(6);
        send(word4(0, 0, 0, 500));
        send(word4(1500, 1500, 1500, 1500)); // Crossing from lane 3 into lane 0
        send(word4(1500, 1500, 1500, 1500));
        send(word4(0, 0, 0, 0));
        settle(14);

        test_name = "valid_gap_no_recross";
        send(word4(0, 0, 1500, 1500));
        send(word4(1500, 1500, 1500, 1500));
        step(1'b0, 1'b0, '0, '0);
        repeat (6) send(word4(1500, 1500, 1500, 1500)); // Still high, no new crossing
        settle(14);

        test_name = "stop_blocks";
        stop_lvl = 1'b1;
        send(word4(0, 0, 1500, 1500));
        repeat (2) send(word4(1500, 1500, 1500, 1500));
        stop_lvl = 1'b0;
        repeat (3) send(word4(1500, 1500, 1500, 1500));
        settle(8);

        test_name = "saturation";
        configure(1000, 200, 3, 2);
        settle(8);
        send_sat(word4(500, 500, 500, 500));
        repeat (4) send(word4(500, 500, 500, 500));
        settle(16);

        test_name = "config_clear";
        send_sat(word4(0, 0, 1500, 1500));
        repeat (4) send(word4(1500, 1500, 1500, 1500));
        configure(1000, 200, 3, 2);
        settle(12);

        test_name = "random";
        for (int seg = 0; seg < 6; seg++) begin
            int r_rise;
            int r_fall;
            int r_pre;
            int r_post;
            r_rise = $random(seed) % 1500;
            r_fall = r_rise - int'($unsigned($random(seed)) % 1500);
            r_pre  = int'($unsigned($random(seed)) % 9);
            r_post = int'($unsigned($random(seed)) % 9);
            configure(r_rise, r_fall, r_pre, r_post);
            repeat (250) random_word();
        end
        stop_lvl = 1'b0;
        settle(20);
        #12; // Last compare at the falling edge
        $display("Test passed");
        $finish;
    end

endmodule
